// File: src/pkt_pkg.sv
/* loopback tester shared definitions */

package pkt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int num_ports   = 2;
    localparam int num_pkt_ids = 4;
    localparam int fifo_depth  = 16;

    // fifo pointer width, depth is a power of two.
    localparam int fifo_addr_w = $clog2(fifo_depth);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] word_t;
    typedef logic [1:0]  pkt_id_t;

    // beat index, also packet length (1 to 255).
    typedef logic [7:0]  beat_count_t;

    // sequence number, also burst size.
    typedef logic [7:0]  pkt_count_t;

    // saturating good/bad counters.
    typedef logic [15:0] stat_count_t;

    // one stream beat, valid/ready travel beside it.
    typedef struct packed {
        word_t   data;
        pkt_id_t id;
        logic    last;
    } stream_t;

    typedef enum logic [1:0] {
        idle,
        send,
        done
    } gen_state_t;

    // drain swallows beats after a length overflow up to the next last.
    typedef enum logic [1:0] {
        wait_start,
        in_packet,
        drain
    } chk_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload rule
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // seq in the top byte, beat next, port in the low half.
    function automatic word_t expected_word(
        input int          port,
        input pkt_count_t  seq,
        input beat_count_t beat
    );
        return {seq, beat, 16'(port)};
    endfunction

endpackage

// File: src/pkt_gen.sv
/* burst packet generator */

module pkt_gen #(
    parameter int port_index = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  pkt_pkg::pkt_count_t  num_pkts,
    input  pkt_pkg::beat_count_t pkt_len,
    output pkt_pkg::stream_t     tx,
    output logic                 tx_valid,
    input  logic                 tx_ready,
    output logic                 busy
);

    pkt_pkg::gen_state_t  state;
    pkt_pkg::pkt_count_t  seq;
    pkt_pkg::beat_count_t beat;
    pkt_pkg::pkt_count_t  num_q;
    pkt_pkg::beat_count_t len_q;
    logic                 last_beat;
    logic                 tx_fire;

    assign tx_valid  = (state == pkt_pkg::send);
    assign busy      = (state == pkt_pkg::send);
    assign tx_fire   = tx_valid && tx_ready;
    assign last_beat = (beat == len_q - pkt_pkg::beat_count_t'(1));

    // beat payload is a pure function of the counters.
    always_comb begin
        tx.data = pkt_pkg::expected_word(port_index, seq, beat);
        tx.id   = pkt_pkg::pkt_id_t'(seq % pkt_pkg::num_pkt_ids);
        tx.last = last_beat;
    end

    // burst config, held for the whole burst.
    always_ff @(posedge clk) begin
        if (start && state != pkt_pkg::send) begin
            num_q <= num_pkts;
            len_q <= pkt_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pkt_pkg::idle;
            seq   <= '0;
            beat  <= '0;
        end else begin
            case (state)
                pkt_pkg::idle, pkt_pkg::done: begin
                    if (start) begin
                        seq   <= '0;
                        beat  <= '0;
                        state <= (num_pkts == '0) ? pkt_pkg::done : pkt_pkg::send;
                    end
                end
                pkt_pkg::send: begin
                    if (tx_fire) begin
                        if (last_beat) begin
                            beat <= '0;
                            seq  <= seq + 1'b1;
                            if (seq == num_q - pkt_pkg::pkt_count_t'(1)) begin
                                state <= pkt_pkg::done;
                            end
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: state <= pkt_pkg::idle;
            endcase
        end
    end

    // a stalled beat must not change or vanish.
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx));

endmodule

// File: src/stream_fifo.sv
/* return stream FIFO */

module stream_fifo (
    input  logic             clk,
    input  logic             rst,
    input  pkt_pkg::stream_t in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output pkt_pkg::stream_t out_data,
    output logic             out_valid
);

    pkt_pkg::stream_t                mem [pkt_pkg::fifo_depth];
    logic [pkt_pkg::fifo_addr_w-1:0] wr_ptr;
    logic [pkt_pkg::fifo_addr_w-1:0] rd_ptr;
    logic [pkt_pkg::fifo_addr_w:0]   count;
    logic                            wr_en;
    logic                            rd_en;
    logic                            empty;

    assign empty    = (count == '0);
    assign in_ready = (count != (pkt_pkg::fifo_addr_w + 1)'(pkt_pkg::fifo_depth));
    assign wr_en    = in_valid && in_ready;

    // consumer never stalls, so pop whenever anything is there.
    // an empty fifo passes the incoming beat straight to the output.
    assign rd_en = !empty || wr_en;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data <= empty ? in_data : mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // pointers wrap on their own.
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> count <= (pkt_pkg::fifo_addr_w + 1)'(pkt_pkg::fifo_depth));

    // an empty fifo keeps its pointers together, so no stale entry is read.
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        empty |-> rd_ptr == wr_ptr);

endmodule

// File: src/pkt_checker.sv
/* returned packet checker */

module pkt_checker #(
    parameter int port_index = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  pkt_pkg::pkt_count_t  num_pkts,
    input  pkt_pkg::beat_count_t pkt_len,
    input  pkt_pkg::stream_t     in_data,
    input  logic                 in_valid,
    output pkt_pkg::stat_count_t good_count,
    output pkt_pkg::stat_count_t bad_count,
    output logic                 pkt_done
);

    pkt_pkg::chk_state_t  state;
    pkt_pkg::pkt_count_t  exp_seq;
    pkt_pkg::beat_count_t beat;
    pkt_pkg::pkt_count_t  num_q;
    pkt_pkg::beat_count_t len_q;
    logic                 armed;
    logic                 pkt_err;
    logic                 active;
    logic                 accept;
    logic                 final_beat;
    logic                 beat_err;
    logic                 pkt_bad;
    pkt_pkg::word_t       exp_word;
    pkt_pkg::pkt_id_t     exp_id;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected beat
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stop listening once the whole burst is seen.
    assign active = armed && (exp_seq != num_q);
    assign accept = in_valid && active;

    always_comb begin
        exp_word   = pkt_pkg::expected_word(port_index, exp_seq, beat);
        exp_id     = pkt_pkg::pkt_id_t'(exp_seq % pkt_pkg::num_pkt_ids);
        final_beat = (beat == len_q - pkt_pkg::beat_count_t'(1));
        beat_err   = (in_data.data != exp_word) || (in_data.id != exp_id) ||
                     (in_data.last && !final_beat);
        pkt_bad    = (state == pkt_pkg::drain) || pkt_err || beat_err;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            num_q <= num_pkts;
            len_q <= pkt_len;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet FSM and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= pkt_pkg::wait_start;
            armed      <= 1'b0;
            exp_seq    <= '0;
            beat       <= '0;
            pkt_err    <= 1'b0;
            good_count <= '0;
            bad_count  <= '0;
            pkt_done   <= 1'b0;
        end else begin
            pkt_done <= 1'b0;
            if (start) begin
                state      <= pkt_pkg::wait_start;
                armed      <= 1'b1;
                exp_seq    <= '0;
                beat       <= '0;
                pkt_err    <= 1'b0;
                good_count <= '0;
                bad_count  <= '0;
            end else if (accept) begin
                if (in_data.last) begin
                    // every last closes a packet, good or not.
                    if (pkt_bad) begin
                        if (bad_count != '1) begin
                            bad_count <= bad_count + 1'b1;
                        end
                    end else if (good_count != '1) begin
                        good_count <= good_count + 1'b1;
                    end
                    pkt_done <= 1'b1;
                    exp_seq  <= exp_seq + 1'b1;
                    beat     <= '0;
                    pkt_err  <= 1'b0;
                    state    <= pkt_pkg::wait_start;
                end else if (state == pkt_pkg::drain) begin
                    state <= pkt_pkg::drain;
                end else if (final_beat) begin
                    // too long, wait out the rest.
                    pkt_err <= 1'b1;
                    state   <= pkt_pkg::drain;
                end else begin
                    beat    <= beat + 1'b1;
                    pkt_err <= pkt_err || beat_err;
                    state   <= pkt_pkg::in_packet;
                end
            end
        end
    end

    // back to back pulses need back to back lasts.
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        pkt_done ##1 pkt_done |->
            $past(in_valid && in_data.last, 1) && $past(in_valid && in_data.last, 2));

endmodule

// File: src/pkt_checker_array.sv
/* per-port FIFO and checker array */

module pkt_checker_array (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  pkt_pkg::pkt_count_t  num_pkts,
    input  pkt_pkg::beat_count_t pkt_len,
    input  pkt_pkg::stream_t     rx         [pkt_pkg::num_ports-1:0],
    input  logic                 rx_valid   [pkt_pkg::num_ports-1:0],
    output logic                 rx_ready   [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t good_count [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t bad_count  [pkt_pkg::num_ports-1:0],
    output logic                 pkt_done   [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t total_good,
    output pkt_pkg::stat_count_t total_bad
);

    pkt_pkg::stream_t fifo_data  [pkt_pkg::num_ports-1:0];
    logic             fifo_valid [pkt_pkg::num_ports-1:0];
    logic [31:0]      good_sum;
    logic [31:0]      bad_sum;

    for (genvar p = 0; p < pkt_pkg::num_ports; p++) begin : g_port
        stream_fifo u_fifo (
            .clk       ( clk           ),
            .rst       ( rst           ),
            .in_data   ( rx[p]         ),
            .in_valid  ( rx_valid[p]   ),
            .in_ready  ( rx_ready[p]   ),
            .out_data  ( fifo_data[p]  ),
            .out_valid ( fifo_valid[p] )
        );

        pkt_checker #(
            .port_index ( p )
        ) u_checker (
            .clk        ( clk           ),
            .rst        ( rst           ),
            .start      ( start         ),
            .num_pkts   ( num_pkts      ),
            .pkt_len    ( pkt_len       ),
            .in_data    ( fifo_data[p]  ),
            .in_valid   ( fifo_valid[p] ),
            .good_count ( good_count[p] ),
            .bad_count  ( bad_count[p]  ),
            .pkt_done   ( pkt_done[p]   )
        );
    end

    always_comb begin
        good_sum = '0;
        bad_sum  = '0;
        for (int p = 0; p < pkt_pkg::num_ports; p++) begin
            good_sum = good_sum + 32'(good_count[p]);
            bad_sum  = bad_sum + 32'(bad_count[p]);
        end
    end

    // totals trail the port counts by one cycle, saturating.
    always_ff @(posedge clk) begin
        if (rst) begin
            total_good <= '0;
            total_bad  <= '0;
        end else begin
            total_good <= (good_sum > 32'(pkt_pkg::stat_count_t'('1))) ?
                          '1 : pkt_pkg::stat_count_t'(good_sum);
            total_bad  <= (bad_sum > 32'(pkt_pkg::stat_count_t'('1))) ?
                          '1 : pkt_pkg::stat_count_t'(bad_sum);
        end
    end

endmodule

// File: src/pkt_check_top.sv
/* stream loopback tester top */

module pkt_check_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  pkt_pkg::pkt_count_t  num_pkts,
    input  pkt_pkg::beat_count_t pkt_len,
    output pkt_pkg::stream_t     tx         [pkt_pkg::num_ports-1:0],
    output logic                 tx_valid   [pkt_pkg::num_ports-1:0],
    input  logic                 tx_ready   [pkt_pkg::num_ports-1:0],
    input  pkt_pkg::stream_t     rx         [pkt_pkg::num_ports-1:0],
    input  logic                 rx_valid   [pkt_pkg::num_ports-1:0],
    output logic                 rx_ready   [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t good_count [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t bad_count  [pkt_pkg::num_ports-1:0],
    output logic                 pkt_done   [pkt_pkg::num_ports-1:0],
    output pkt_pkg::stat_count_t total_good,
    output pkt_pkg::stat_count_t total_bad,
    output logic                 busy
);

    logic [pkt_pkg::num_ports-1:0] gen_busy;
    logic                          start_ok;

    // a start during a burst is dropped everywhere.
    assign busy     = |gen_busy;
    assign start_ok = start && !busy;

    for (genvar p = 0; p < pkt_pkg::num_ports; p++) begin : g_gen
        pkt_gen #(
            .port_index ( p )
        ) u_gen (
            .clk      ( clk         ),
            .rst      ( rst         ),
            .start    ( start_ok    ),
            .num_pkts ( num_pkts    ),
            .pkt_len  ( pkt_len     ),
            .tx       ( tx[p]       ),
            .tx_valid ( tx_valid[p] ),
            .tx_ready ( tx_ready[p] ),
            .busy     ( gen_busy[p] )
        );
    end

    pkt_checker_array u_checkers (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .start      ( start_ok   ),
        .num_pkts   ( num_pkts   ),
        .pkt_len    ( pkt_len    ),
        .rx         ( rx         ),
        .rx_valid   ( rx_valid   ),
        .rx_ready   ( rx_ready   ),
        .good_count ( good_count ),
        .bad_count  ( bad_count  ),
        .pkt_done   ( pkt_done   ),
        .total_good ( total_good ),
        .total_bad  ( total_bad  )
    );

endmodule

// File: bench/pkt_check_tb.sv
/* loopback tester testbench */

module pkt_check_tb;

    localparam int n_tests = 5;

    typedef enum logic [2:0] {
        f_none,
        f_flip,
        f_trunc,
        f_stretch,
        f_id
    } fault_kind_t;

    typedef struct packed {
        logic [7:0]  port;
        logic [7:0]  pkt;
        fault_kind_t kind;
    } fault_t;

    typedef struct packed {
        pkt_pkg::stat_count_t good;
        pkt_pkg::stat_count_t bad;
    } count_pair_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 start;
    pkt_pkg::pkt_count_t  num_pkts;
    pkt_pkg::beat_count_t pkt_len;
    pkt_pkg::stream_t     tx         [pkt_pkg::num_ports-1:0];
    logic                 tx_valid   [pkt_pkg::num_ports-1:0];
    logic                 tx_ready   [pkt_pkg::num_ports-1:0] = '{default: 1'b0};
    pkt_pkg::stream_t     rx         [pkt_pkg::num_ports-1:0] = '{default: '0};
    logic                 rx_valid   [pkt_pkg::num_ports-1:0] = '{default: 1'b0};
    logic                 rx_ready   [pkt_pkg::num_ports-1:0];
    pkt_pkg::stat_count_t good_count [pkt_pkg::num_ports-1:0];
    pkt_pkg::stat_count_t bad_count  [pkt_pkg::num_ports-1:0];
    logic                 pkt_done   [pkt_pkg::num_ports-1:0];
    pkt_pkg::stat_count_t total_good;
    pkt_pkg::stat_count_t total_bad;
    logic                 busy;

    // burst shape per test.
    int test_pkts [n_tests] = '{12, 20, 10, 10, 8};
    int test_len  [n_tests] = '{5, 7, 4, 6, 3};

    pkt_pkg::stream_t rx_q [pkt_pkg::num_ports][$];
    fault_t           faults[$];
    int               tx_pkt    [pkt_pkg::num_ports];
    int               tx_beat   [pkt_pkg::num_ports];
    int               done_seen [pkt_pkg::num_ports];
    int               gap_left  [pkt_pkg::num_ports];
    int               cur_len = 1;
    bit               stall_en = 1'b0;
    bit               gap_en = 1'b0;
    int               errors = 0;
    int               checks = 0;

    pkt_check_top UUT (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .start      ( start      ),
        .num_pkts   ( num_pkts   ),
        .pkt_len    ( pkt_len    ),
        .tx         ( tx         ),
        .tx_valid   ( tx_valid   ),
        .tx_ready   ( tx_ready   ),
        .rx         ( rx         ),
        .rx_valid   ( rx_valid   ),
        .rx_ready   ( rx_ready   ),
        .good_count ( good_count ),
        .bad_count  ( bad_count  ),
        .pkt_done   ( pkt_done   ),
        .total_good ( total_good ),
        .total_bad  ( total_bad  ),
        .busy       ( busy       )
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fault list and reference
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_fault(input int port, input int pkt, input fault_kind_t kind);
        fault_t f;
        f.port = 8'(port);
        f.pkt  = 8'(pkt);
        f.kind = kind;
        faults.push_back(f);
    endtask

    function automatic fault_kind_t fault_at(input int port, input int pkt);
        fault_kind_t kind;
        kind = f_none;
        foreach (faults[i]) begin
            if (int'(faults[i].port) == port && int'(faults[i].pkt) == pkt) begin
                kind = faults[i].kind;
            end
        end
        return kind;
    endfunction

    // each fault spoils exactly one packet, the rest come back clean.
    function automatic count_pair_t ref_counts(input int port, input int n);
        count_pair_t r;
        int          hits;
        hits = 0;
        foreach (faults[i]) begin
            if (int'(faults[i].port) == port) begin
                hits++;
            end
        end
        r.bad  = pkt_pkg::stat_count_t'(hits);
        r.good = pkt_pkg::stat_count_t'(n - hits);
        return r;
    endfunction

    // expected tx beat, seq in the top byte, beat index next, port below.
    function automatic pkt_pkg::stream_t rule_beat(
        input int port,
        input int seq,
        input int beat
    );
        pkt_pkg::stream_t s;
        s.data = (32'(seq) << 24) | (32'(beat) << 16) | 32'(port);
        s.id   = pkt_pkg::pkt_id_t'(seq % pkt_pkg::num_pkt_ids);
        s.last = (beat == cur_len - 1);
        return s;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // loopback model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic loop_beat(input int p, input pkt_pkg::stream_t b);
        fault_kind_t      kind;
        pkt_pkg::stream_t extra;
        pkt_pkg::stream_t exp_beat;
        logic             true_last;
        int               cut;
        kind      = fault_at(p, tx_pkt[p]);
        true_last = b.last;
        cut       = (cur_len - 1) / 2;
        exp_beat  = rule_beat(p, tx_pkt[p], tx_beat[p]);
        checks++;
        assert (b == exp_beat) else begin
            errors++;
            $display("Mismatch tx[%0d]: expected %h, got %h", p, exp_beat, b);
        end
        case (kind)
            f_flip: begin
                if (tx_beat[p] == 0) begin
                    b.data = b.data ^ 32'h8000_0001;
                end
                rx_q[p].push_back(b);
            end
            f_id: begin
                b.id = b.id ^ 2'b01;
                rx_q[p].push_back(b);
            end
            f_trunc: begin
                // last moves up to the cut, later beats are dropped.
                if (tx_beat[p] == cut) begin
                    b.last = 1'b1;
                end
                if (tx_beat[p] <= cut) begin
                    rx_q[p].push_back(b);
                end
            end
            f_stretch: begin
                if (b.last) begin
                    b.last = 1'b0;
                    rx_q[p].push_back(b);
                    extra      = b;
                    extra.data = ~b.data;
                    rx_q[p].push_back(extra);
                    extra.last = 1'b1;
                    rx_q[p].push_back(extra);
                end else begin
                    rx_q[p].push_back(b);
                end
            end
            default: rx_q[p].push_back(b);
        endcase
        if (true_last) begin
            tx_pkt[p]  = tx_pkt[p] + 1;
            tx_beat[p] = 0;
        end else begin
            tx_beat[p] = tx_beat[p] + 1;
        end
    endtask

    always @(posedge clk) begin
        for (int p = 0; p < pkt_pkg::num_ports; p++) begin
            if (rst) begin
                rx_q[p].delete();
                tx_ready[p] <= 1'b0;
                rx_valid[p] <= 1'b0;
                gap_left[p] = 0;
                done_seen[p] = 0;
            end else begin
                if (start) begin
                    tx_pkt[p]    = 0;
                    tx_beat[p]   = 0;
                    done_seen[p] = 0;
                end else if (pkt_done[p]) begin
                    done_seen[p] = done_seen[p] + 1;
                end
                if (tx_valid[p] && tx_ready[p]) begin
                    loop_beat(p, tx[p]);
                end
                tx_ready[p] <= stall_en ? ($urandom % 4 != 0) : 1'b1;
                if (rx_valid[p] && rx_ready[p]) begin
                    void'(rx_q[p].pop_front());
                end
                // a beat not yet taken stays on the bus.
                if (!(rx_valid[p] && !rx_ready[p])) begin
                    if (gap_left[p] > 0) begin
                        gap_left[p] = gap_left[p] - 1;
                    end else if (gap_en && $urandom % 32 == 0) begin
                        // long gaps let the holding queue build up.
                        gap_left[p] = 1 + int'($urandom % 24);
                    end
                    if (gap_left[p] == 0 && rx_q[p].size() > 0) begin
                        rx[p]       <= rx_q[p][0];
                        rx_valid[p] <= 1'b1;
                    end else begin
                        rx_valid[p] <= 1'b0;
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input int act, input int exp);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // counts clear on start, totals one cycle behind.
    task automatic check_cleared();
        repeat (2) @(negedge clk);
        for (int p = 0; p < pkt_pkg::num_ports; p++) begin
            check_value($sformatf("good_count[%0d] after start", p), int'(good_count[p]), 0);
            check_value($sformatf("bad_count[%0d] after start", p), int'(bad_count[p]), 0);
        end
        check_value("total_good after start", int'(total_good), 0);
        check_value("total_bad after start", int'(total_bad), 0);
    endtask

    task automatic wait_done(input int n);
        bit all_done;
        all_done = 1'b0;
        while (!all_done) begin
            @(negedge clk);
            all_done = !busy;
            for (int p = 0; p < pkt_pkg::num_ports; p++) begin
                if (done_seen[p] < n) begin
                    all_done = 1'b0;
                end
            end
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic compare_counts(input int n);
        count_pair_t exp;
        int          sum_good;
        int          sum_bad;
        sum_good = 0;
        sum_bad  = 0;
        for (int p = 0; p < pkt_pkg::num_ports; p++) begin
            exp      = ref_counts(p, n);
            sum_good = sum_good + int'(exp.good);
            sum_bad  = sum_bad + int'(exp.bad);
            check_value($sformatf("good_count[%0d]", p), int'(good_count[p]), int'(exp.good));
            check_value($sformatf("bad_count[%0d]", p), int'(bad_count[p]), int'(exp.bad));
            check_value($sformatf("pkt_done count[%0d]", p), done_seen[p], n);
            checks++;
            assert (rx_q[p].size() == 0) else begin
                errors++;
                $display("port %0d still holds %0d returned beats", p, rx_q[p].size());
            end
        end
        check_value("total_good", int'(total_good), sum_good);
        check_value("total_bad", int'(total_bad), sum_bad);
    endtask

    task automatic run_test(input int idx, input bit noisy);
        @(negedge clk);
        cur_len  = test_len[idx];
        stall_en = noisy;
        gap_en   = noisy;
        $display("test %0d: %0d packets of %0d beats", idx + 1, test_pkts[idx], test_len[idx]);
        @(posedge clk);
        start    <= 1'b1;
        num_pkts <= pkt_pkg::pkt_count_t'(test_pkts[idx]);
        pkt_len  <= pkt_pkg::beat_count_t'(test_len[idx]);
        @(posedge clk);
        start <= 1'b0;
        check_cleared();
        wait_done(test_pkts[idx]);
        compare_counts(test_pkts[idx]);
        faults.delete();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h043a_1690));
        rst      = 1'b1;
        start    = 1'b0;
        num_pkts = '0;
        pkt_len  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        run_test(0, 1'b0);
        run_test(1, 1'b1);
        add_fault(1, 3, f_flip);
        run_test(2, 1'b1);
        add_fault(0, 2, f_trunc);
        add_fault(0, 5, f_stretch);
        add_fault(1, 0, f_trunc);
        add_fault(1, 7, f_stretch);
        run_test(3, 1'b1);
        add_fault(0, 4, f_id);
        run_test(4, 1'b0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < n_tests; i++) begin
            limit = limit + test_pkts[i] * test_len[i];
        end
        limit = limit * 20 + 2000;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bursts never finished", limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: src.f
src/pkt_pkg.sv
src/pkt_gen.sv
src/stream_fifo.sv
src/pkt_checker.sv
src/pkt_checker_array.sv
src/pkt_check_top.sv
bench/pkt_check_tb.sv

// File: run.sh
#!/bin/sh
# build the loopback tester testbench with Verilator, run it, and
# decide the result from the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pkt_check_tb -f src.f \
    -Mdir obj_dir -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -qx "Simulation completed successfully" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }
